// File: design/cpu_pkg.sv
// Core-wide definitions for the 16-bit five-stage pipeline
// Word and register types, opcodes, branch conditions, flag bits
// and the payloads carried between pipeline stages

`default_nettype none

package cpu_pkg;

  typedef logic [15:0] word_t;     // Data, address and instruction word
  typedef logic [3:0]  reg_idx_t;  // R0 reads as zero

  // Opcode in instr[15:12]; unlisted codes act as NOP
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_XOR = 4'h2,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_LLB = 4'hA,
    OP_LHB = 4'hB,
    OP_B   = 4'hC,
    OP_HLT = 4'hF
  } opcode_e;

  // Branch condition in instr[11:9]
  typedef enum logic [2:0] {
    C_NE = 3'd0,  // Z clear
    C_EQ = 3'd1,  // Z set
    C_GT = 3'd2,  // Z and N clear
    C_LT = 3'd3,  // N set
    C_GE = 3'd4,  // N clear
    C_LE = 3'd5,  // Z or N set
    C_OV = 3'd6,  // V set
    C_UN = 3'd7   // Always
  } cond_e;

  // Operation performed in execute
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_ADDI,  // Base plus offset for LW and SW
    ALU_LLB,   // Low byte replaced by imm
    ALU_LHB    // High byte replaced by imm
  } alu_op_e;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flags_t;

  ///////////////////////////////////////////////////
  // Stage payloads, all zero is a bubble
  ///////////////////////////////////////////////////
  typedef struct packed {
    word_t instr;
    word_t pc;
  } if_id_t;

  typedef struct packed {
    reg_idx_t   rs;       // First source, also old rd for byte loads
    reg_idx_t   rt;       // Second source, store data for SW
    word_t      a;
    word_t      b;
    logic [7:0] imm;      // imm8 or offset already doubled
    alu_op_e    alu_op;
    logic       z_en;
    logic       nv_en;
    logic       mem_en;
    logic       mem_wr;
    reg_idx_t   rd;
    logic       reg_wr;
    logic       is_halt;
  } id_ex_t;

  typedef struct packed {
    word_t    result;      // ALU result or data address
    word_t    store_data;
    reg_idx_t store_src;
    logic     mem_en;
    logic     mem_wr;
    reg_idx_t rd;
    logic     reg_wr;
    logic     mem_to_reg;
    logic     is_halt;
  } ex_mem_t;

  typedef struct packed {
    word_t    result;
    reg_idx_t rd;
    logic     reg_wr;
    logic     is_halt;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: design/pipe_reg.sv
// Pipeline stage register
// Loads the stage payload each cycle, keeps it on hold and
// drops in a bubble (all zero) on flush

`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     hold,   // Freeze or stall from upstream
  input  logic     flush,  // Replace content with a bubble
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;                // Bubble out of reset
    end else if (flush) begin
      q <= '0;
    end else if (!hold) begin
      q <= d;
    end
  end

  // Flush comes from hazard logic and hold from the arbiter, they must not meet
  a_no_flush_on_hold: assert property (@(posedge clk) disable iff (!arst_n) !(flush && hold))
    else $error("pipe_reg flushed while held");

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
// Program counter
// Steps by one instruction after an accepted fetch and
// jumps to the decode-stage branch target on redirect

`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter cpu_pkg::word_t RESET_PC = 16'h0000
) (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           advance,   // Fetch accepted into if_id
  input  logic           redirect,  // Taken branch in decode
  input  cpu_pkg::word_t target,
  output cpu_pkg::word_t pc
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= RESET_PC;
    end else if (redirect) begin
      pc <= target;           // Redirect wins over advance
    end else if (advance) begin
      pc <= pc + 16'd2;       // Next halfword instruction
    end
  end

endmodule

`default_nettype wire

// File: design/decode_unit.sv
// Instruction decode stage
// Splits the instruction into fields, reads the register file
// with write-through from write-back, builds the execute payload
// and resolves conditional branches against the flag register

`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  logic             clk,
  input  logic             arst_n,
  input  cpu_pkg::if_id_t  if_id,
  input  cpu_pkg::flags_t  flags,
  input  cpu_pkg::mem_wb_t wb,
  output cpu_pkg::id_ex_t  id_ex,
  output logic             branch_taken,
  output cpu_pkg::word_t   branch_target,
  output logic             reads_flags
);
  import cpu_pkg::*;

  word_t    rf [16];     // Register file
  opcode_e  op;
  reg_idx_t f_hi;        // instr[11:8]
  reg_idx_t f_mid;       // instr[7:4]
  reg_idx_t f_lo;        // instr[3:0]
  cond_e    cond;
  logic     cond_met;
  logic     is_bubble;

  assign op        = opcode_e'(if_id.instr[15:12]);
  assign f_hi      = if_id.instr[11:8];
  assign f_mid     = if_id.instr[7:4];
  assign f_lo      = if_id.instr[3:0];
  assign cond      = cond_e'(if_id.instr[11:9]);
  assign is_bubble = (if_id.instr == '0);  // Flushed slot, no flag update

  //////////////////////////////////////////////////
  // Register file, written from write-back
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 16; i++) begin
        rf[i] <= '0;
      end
    end else if (wb.reg_wr && wb.rd != '0) begin
      rf[wb.rd] <= wb.result;  // R0 never written
    end
  end

  //////////////////////////////////////////////////
  // Field decode and operand read
  //////////////////////////////////////////////////
  always_comb begin
    id_ex    = '0;
    id_ex.rs = f_mid;
    id_ex.rt = f_lo;
    id_ex.rd = f_hi;
    case (op)
      OP_ADD, OP_SUB, OP_XOR: begin
        id_ex.alu_op = (op == OP_ADD) ? ALU_ADD : (op == OP_SUB) ? ALU_SUB : ALU_XOR;
        id_ex.z_en   = 1'b1;
        id_ex.nv_en  = (op != OP_XOR);  // XOR touches Z only
        id_ex.reg_wr = 1'b1;
      end
      OP_LW, OP_SW: begin
        id_ex.rt     = f_hi;            // Load target or store data
        id_ex.alu_op = ALU_ADDI;
        id_ex.imm    = {{3{if_id.instr[3]}}, if_id.instr[3:0], 1'b0};
        id_ex.mem_en = 1'b1;
        id_ex.mem_wr = (op == OP_SW);
        id_ex.reg_wr = (op == OP_LW);
      end
      OP_LLB, OP_LHB: begin
        id_ex.rs     = f_hi;            // Old rd merged with imm8
        id_ex.alu_op = (op == OP_LLB) ? ALU_LLB : ALU_LHB;
        id_ex.imm    = if_id.instr[7:0];
        id_ex.reg_wr = 1'b1;
      end
      OP_HLT:  id_ex.is_halt = 1'b1;
      default: ;                        // B and unused codes write nothing
    endcase
    if (is_bubble) begin
      id_ex = '0;
    end
    // Read with write-through of the write-back result
    id_ex.a = rf[id_ex.rs];
    id_ex.b = rf[id_ex.rt];
    if (wb.reg_wr && wb.rd != '0) begin
      if (wb.rd == id_ex.rs) id_ex.a = wb.result;
      if (wb.rd == id_ex.rt) id_ex.b = wb.result;
    end
  end

  //////////////////////////////////////////////////
  // Branch resolution
  //////////////////////////////////////////////////
  always_comb begin
    case (cond)
      C_NE:    cond_met = !flags.z;
      C_EQ:    cond_met = flags.z;
      C_GT:    cond_met = !flags.z && !flags.n;
      C_LT:    cond_met = flags.n;
      C_GE:    cond_met = !flags.n;
      C_LE:    cond_met = flags.z || flags.n;
      C_OV:    cond_met = flags.v;
      default: cond_met = 1'b1;         // Unconditional
    endcase
  end

  assign reads_flags   = (op == OP_B) && (cond != C_UN);  // UN never waits on flags
  assign branch_taken  = (op == OP_B) && cond_met;
  assign branch_target = if_id.pc + 16'd2 + {{6{if_id.instr[8]}}, if_id.instr[8:0], 1'b0};

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
// Hazard detection
// Load-use and flag-wait stalls hold PC and if_id and put a
// bubble into id_ex. A taken branch flushes its shadow slot

`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  cpu_pkg::id_ex_t id_ex,         // Instruction in execute
  input  cpu_pkg::if_id_t if_id,         // Instruction in decode
  input  logic            is_branch,     // B in decode that tests flags
  input  logic            branch_taken,
  output logic            stall,
  output logic            flush_if
);
  import cpu_pkg::*;

  opcode_e op;
  logic    uses_rs;    // instr[7:4] read
  logic    uses_rt;    // instr[3:0] read
  logic    uses_hi;    // instr[11:8] read
  logic    load_use;
  logic    flag_wait;

  assign op      = opcode_e'(if_id.instr[15:12]);
  assign uses_rs = op inside {OP_ADD, OP_SUB, OP_XOR, OP_LW, OP_SW};
  assign uses_rt = op inside {OP_ADD, OP_SUB, OP_XOR};
  assign uses_hi = op inside {OP_LLB, OP_LHB};  // SW data comes late, forwarded in memory stage

  // LW in execute whose target decode needs now
  assign load_use = id_ex.mem_en && !id_ex.mem_wr && (id_ex.rd != '0) &&
                    ((uses_rs && if_id.instr[7:4] == id_ex.rd) ||
                     (uses_rt && if_id.instr[3:0] == id_ex.rd) ||
                     (uses_hi && if_id.instr[11:8] == id_ex.rd));

  assign flag_wait = is_branch && (id_ex.z_en || id_ex.nv_en);  // Flags not yet registered
  assign stall     = load_use || flag_wait;

  // B reads no registers, so only the flag wait can hide a taken branch
  assign flush_if = branch_taken && !flag_wait;

  always_comb begin
    a_no_flush_in_stall: assert final (!(flush_if && stall))
      else $error("branch flush during stall");
  end

endmodule

`default_nettype wire

// File: design/execute_unit.sv
// Execute stage
// Operand forwarding, ALU for add, subtract, xor, address and
// byte merges, and the Z/N/V flag register

`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             hold,        // Pipeline frozen
  input  cpu_pkg::id_ex_t  id_ex,
  input  cpu_pkg::ex_mem_t ex_mem_fwd,  // Newer producer
  input  cpu_pkg::mem_wb_t mem_wb_fwd,  // Older producer
  output cpu_pkg::ex_mem_t ex_mem,
  output cpu_pkg::flags_t  flags
);
  import cpu_pkg::*;

  word_t op_a;
  word_t op_b;        // Also the store data
  word_t imm_ext;
  word_t sum;
  word_t diff;
  word_t res;
  logic  v_add;
  logic  v_sub;

  // Newest producer wins, a load in memory stage has no data yet
  function automatic word_t fwd(input reg_idx_t idx, input word_t reg_val,
                                input ex_mem_t m, input mem_wb_t w);
    if (idx != '0 && m.reg_wr && !m.mem_to_reg && m.rd == idx) return m.result;
    if (idx != '0 && w.reg_wr && w.rd == idx) return w.result;
    return reg_val;
  endfunction

  assign op_a    = fwd(id_ex.rs, id_ex.a, ex_mem_fwd, mem_wb_fwd);
  assign op_b    = fwd(id_ex.rt, id_ex.b, ex_mem_fwd, mem_wb_fwd);
  assign imm_ext = {{8{id_ex.imm[7]}}, id_ex.imm};
  assign sum     = op_a + op_b;
  assign diff    = op_a - op_b;
  assign v_add   = (op_a[15] == op_b[15]) && (sum[15] != op_a[15]);   // Signed overflow
  assign v_sub   = (op_a[15] != op_b[15]) && (diff[15] != op_a[15]);

  always_comb begin
    case (id_ex.alu_op)
      ALU_ADD:  res = sum;
      ALU_SUB:  res = diff;
      ALU_XOR:  res = op_a ^ op_b;
      ALU_ADDI: res = op_a + imm_ext;
      ALU_LLB:  res = {op_a[15:8], id_ex.imm};
      ALU_LHB:  res = {id_ex.imm, op_a[7:0]};
      default:  res = op_a;
    endcase
  end

  // Flags update as the instruction leaves execute
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags <= '0;
    end else if (!hold) begin
      if (id_ex.z_en) flags.z <= (res == '0);
      if (id_ex.nv_en) begin
        flags.n <= res[15];
        flags.v <= (id_ex.alu_op == ALU_SUB) ? v_sub : v_add;
      end
    end
  end

  always_comb begin
    ex_mem            = '0;
    ex_mem.result     = res;
    ex_mem.store_data = op_b;
    ex_mem.store_src  = id_ex.rt;
    ex_mem.mem_en     = id_ex.mem_en;
    ex_mem.mem_wr     = id_ex.mem_wr;
    ex_mem.rd         = id_ex.rd;
    ex_mem.reg_wr     = id_ex.reg_wr;
    ex_mem.mem_to_reg = id_ex.mem_en && !id_ex.mem_wr;
    ex_mem.is_halt    = id_ex.is_halt;
  end

endmodule

`default_nettype wire

// File: design/mem_arbiter.sv
// Memory port arbiter
// The data access of the memory stage goes first, then the fetch
// at pc. Freeze holds the whole pipeline until both are through

`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic             clk,
  input  logic             arst_n,
  input  cpu_pkg::ex_mem_t ex_mem,
  input  cpu_pkg::word_t   pc,
  input  logic             halted,          // No more fetches
  input  logic             mem_data_valid,
  input  cpu_pkg::word_t   mem_data_in,
  output logic             mem_en,
  output cpu_pkg::word_t   mem_addr,
  output logic             mem_wr,
  output cpu_pkg::word_t   mem_data_out,
  output cpu_pkg::word_t   fetch_word,
  output logic             fetch_done,
  output cpu_pkg::word_t   load_word,
  output logic             freeze
);
  import cpu_pkg::*;

  logic  active;      // Low for the first cycle out of reset
  logic  data_done;   // Data access of this step completed
  logic  data_pend;
  logic  fetch_req;
  word_t load_q;      // Load data kept until the step advances

  assign data_pend    = active && ex_mem.mem_en && !data_done;
  assign fetch_req    = active && !data_pend && !halted;
  assign mem_en       = data_pend || fetch_req;
  assign mem_addr     = data_pend ? ex_mem.result : pc;
  assign mem_wr       = data_pend && ex_mem.mem_wr;
  assign mem_data_out = ex_mem.store_data;
  assign fetch_word   = mem_data_in;
  assign fetch_done   = fetch_req && mem_data_valid;
  assign load_word    = load_q;
  assign freeze       = !active || data_pend || (fetch_req && !mem_data_valid);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      active    <= 1'b0;
      data_done <= 1'b0;
    end else begin
      active <= 1'b1;
      if (!freeze) begin
        data_done <= 1'b0;                    // New memory-stage entry
      end else if (data_pend && mem_data_valid) begin
        data_done <= 1'b1;                    // Fetch follows next cycle
      end
    end
  end

  always_ff @(posedge clk) begin
    if (data_pend && mem_data_valid) load_q <= mem_data_in;
  end

  // Request held until acknowledged, across arbiter, PC and stage registers
  a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
    mem_en && !mem_data_valid |=> mem_en && $stable(mem_addr))
    else $error("memory request changed before completion");

endmodule

`default_nettype wire

// File: design/proc.sv
// Five-stage pipelined 16-bit processor core
// Fetch, decode, execute, memory and write-back around one external
// memory port with a valid handshake. Branches resolve in decode,
// predicted not-taken. hlt latches once HLT reaches write-back

`timescale 1ns/1ps
`default_nettype none

module proc #(
  parameter cpu_pkg::word_t RESET_PC = 16'h0000
) (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           mem_data_valid,
  input  cpu_pkg::word_t mem_data_in,
  output logic           mem_en,
  output cpu_pkg::word_t mem_addr,
  output logic           mem_wr,
  output cpu_pkg::word_t mem_data_out,
  output logic           hlt,
  output cpu_pkg::word_t pc
);
  import cpu_pkg::*;

  if_id_t  if_id_d, if_id_q;
  id_ex_t  id_ex_d, id_ex_q;
  ex_mem_t ex_mem_d, ex_mem_q;
  ex_mem_t ex_mem_port;     // Memory stage with late store data
  mem_wb_t mem_wb_d, mem_wb_q;
  flags_t  flags;
  word_t   branch_target;
  word_t   fetch_word;
  word_t   load_word;
  logic    branch_taken, reads_flags;
  logic    stall, flush_if, freeze;
  logic    fetch_done, halted;

  // Any HLT in flight stops fetching
  assign halted = hlt || id_ex_d.is_halt || id_ex_q.is_halt ||
                  ex_mem_q.is_halt || mem_wb_q.is_halt;

  //////////////////////////////////////////////////
  // Fetch
  //////////////////////////////////////////////////
  fetch_unit #(.RESET_PC(RESET_PC)) fetch_inst (
    .clk(clk), .arst_n(arst_n),
    .advance(fetch_done && !stall),
    .redirect(flush_if && !freeze),   // Only on an advancing step
    .target(branch_target),
    .pc(pc)
  );

  assign if_id_d = fetch_done ? '{instr: fetch_word, pc: pc} : '0;  // Bubble when halted

  pipe_reg #(.payload_t(if_id_t)) if_id_reg (
    .clk(clk), .arst_n(arst_n),
    .hold(freeze || stall), .flush(flush_if && !freeze),
    .d(if_id_d), .q(if_id_q)
  );

  //////////////////////////////////////////////////
  // Decode and hazards
  //////////////////////////////////////////////////
  decode_unit decode_inst (
    .clk(clk), .arst_n(arst_n),
    .if_id(if_id_q), .flags(flags), .wb(mem_wb_q),
    .id_ex(id_ex_d), .branch_taken(branch_taken),
    .branch_target(branch_target), .reads_flags(reads_flags)
  );

  hazard_unit hazard_inst (
    .id_ex(id_ex_q), .if_id(if_id_q),
    .is_branch(reads_flags), .branch_taken(branch_taken),
    .stall(stall), .flush_if(flush_if)
  );

  pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
    .clk(clk), .arst_n(arst_n),
    .hold(freeze), .flush(stall && !freeze),  // Bubble behind a stalled decode
    .d(id_ex_d), .q(id_ex_q)
  );

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////
  execute_unit execute_inst (
    .clk(clk), .arst_n(arst_n), .hold(freeze),
    .id_ex(id_ex_q), .ex_mem_fwd(ex_mem_q), .mem_wb_fwd(mem_wb_q),
    .ex_mem(ex_mem_d), .flags(flags)
  );

  pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
    .clk(clk), .arst_n(arst_n), .hold(freeze), .flush(1'b0),
    .d(ex_mem_d), .q(ex_mem_q)
  );

  //////////////////////////////////////////////////
  // Memory stage and write-back
  //////////////////////////////////////////////////
  // SW right behind its producer picks the data up from write-back
  always_comb begin
    ex_mem_port = ex_mem_q;
    if (mem_wb_q.reg_wr && mem_wb_q.rd != '0 && mem_wb_q.rd == ex_mem_q.store_src) begin
      ex_mem_port.store_data = mem_wb_q.result;
    end
  end

  mem_arbiter arbiter_inst (
    .clk(clk), .arst_n(arst_n),
    .ex_mem(ex_mem_port), .pc(pc), .halted(halted),
    .mem_data_valid(mem_data_valid), .mem_data_in(mem_data_in),
    .mem_en(mem_en), .mem_addr(mem_addr), .mem_wr(mem_wr), .mem_data_out(mem_data_out),
    .fetch_word(fetch_word), .fetch_done(fetch_done),
    .load_word(load_word), .freeze(freeze)
  );

  assign mem_wb_d = '{result:  ex_mem_q.mem_to_reg ? load_word : ex_mem_q.result,
                      rd:      ex_mem_q.rd,
                      reg_wr:  ex_mem_q.reg_wr,
                      is_halt: ex_mem_q.is_halt};

  pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
    .clk(clk), .arst_n(arst_n), .hold(freeze), .flush(1'b0),
    .d(mem_wb_d), .q(mem_wb_q)
  );

  // Sticky halt, one cycle after HLT sits in write-back
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hlt <= 1'b0;
    end else if (mem_wb_q.is_halt) begin
      hlt <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verification/proc_mem_model.sv
// Behavioral memory for the core's single port
// Answers each request after 0 to 3 random idle cycles, logs every
// write as an address and data pair and counts accepted requests

`timescale 1ns/1ps
`default_nettype none

module proc_mem_model #(
  parameter int SEED = 25580
) (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           mem_en,
  input  cpu_pkg::word_t mem_addr,
  input  logic           mem_wr,
  input  cpu_pkg::word_t mem_data_out,
  output logic           mem_data_valid,
  output cpu_pkg::word_t mem_data_in
);
  import cpu_pkg::*;

  word_t mem [256];        // Word array, byte address bits 8:1
  word_t log_addr [16];    // Store log
  word_t log_data [16];
  int    log_cnt;          // Keeps counting past the log size
  int    req_cnt;          // Requests accepted since reset

  // One process, so the seed covers every draw
  initial begin
    logic  busy;
    int    wait_cnt;
    logic  rst_s;
    logic  en_s;
    logic  valid_s;
    logic  wr_q;
    word_t addr_q;
    word_t data_q;
    busy           = 1'b0;
    wait_cnt       = 0;
    wr_q           = 1'b0;
    addr_q         = '0;
    data_q         = '0;
    mem_data_valid = 1'b0;
    mem_data_in    = '0;
    log_cnt        = 0;
    req_cnt        = 0;
    void'($urandom(SEED));
    forever begin
      @(posedge clk);
      rst_s   = arst_n;          // Values of the cycle that just ended
      en_s    = mem_en;
      valid_s = mem_data_valid;
      if (!busy && en_s) begin
        wr_q   = mem_wr;
        addr_q = mem_addr;
        data_q = mem_data_out;
      end
      #2;
      if (!rst_s) begin
        busy           = 1'b0;
        mem_data_valid = 1'b0;
        log_cnt        = 0;
        req_cnt        = 0;
      end else if (valid_s) begin
        mem_data_valid = 1'b0;   // Request completed at this edge
        busy           = 1'b0;
      end else begin
        if (!busy && en_s) begin
          busy     = 1'b1;
          wait_cnt = $urandom % 4;
          req_cnt++;
        end
        if (busy && wait_cnt == 0) begin
          if (wr_q) begin
            mem[addr_q[8:1]] = data_q;
            if (log_cnt < 16) begin
              log_addr[log_cnt] = addr_q;
              log_data[log_cnt] = data_q;
            end
            log_cnt++;
          end else begin
            mem_data_in = mem[addr_q[8:1]];
          end
          mem_data_valid = 1'b1; // Ack or read data
        end else if (busy) begin
          wait_cnt--;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/proc_tb.sv
// Testbench for the pipelined core
// Runs a table of short programs, each ending in HLT, against a
// memory with random latency, then checks the logged stores and
// that the core stays halted with pc frozen

`timescale 1ns/1ps
`default_nettype none

module proc_tb;
  import cpu_pkg::*;

  localparam int N_TESTS     = 6;
  localparam int HLT_TIMEOUT = 2000;  // Cycles
  localparam int HOLD_CYCLES = 20;

  logic  clk;
  logic  arst_n;
  logic  mem_data_valid;
  word_t mem_data_in;
  logic  mem_en;
  logic  mem_wr;
  logic  hlt;
  word_t mem_addr;
  word_t mem_data_out;
  word_t pc;
  int    errors;

  //////////////////////////////////////////////////
  // Test table, expected stores by the ISA rules
  //////////////////////////////////////////////////
  string test_name [N_TESTS] = '{"alu_byte_loads", "forwarding", "load_use",
                                 "branches", "overflow", "halt"};
  word_t program_tab [N_TESTS][16] = '{
    '{16'hA134, 16'hB112, 16'hA278, 16'hB256, 16'hAF80, 16'h0312, 16'h1421, 16'h2512,
      16'h93F0, 16'h94F1, 16'h95F2, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
    '{16'hAF80, 16'hA105, 16'h0211, 16'h0321, 16'h1432, 16'h2543, 16'h95F0, 16'h93FF,
      16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
    '{16'hAF80, 16'hA121, 16'hB143, 16'h91F0, 16'h82F0, 16'h0321, 16'h93F1, 16'h84F1,
      16'h94F2, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
    '{16'hAF80, 16'hA103, 16'hA205, 16'h1012, 16'hC601, 16'hA611, 16'hC201, 16'hA722,
      16'hC401, 16'hA833, 16'hCA01, 16'hA899, 16'h96F0, 16'h97F1, 16'h98F2, 16'hF000},
    '{16'hAF80, 16'hA1FF, 16'hB17F, 16'hA201, 16'h0312, 16'hCC01, 16'hA455, 16'h93F0,
      16'h94F1, 16'h0522, 16'hCC01, 16'hA466, 16'h94F2, 16'hF000, 16'hF000, 16'hF000},
    '{16'hAF80, 16'hA15A, 16'h91F0, 16'hF000, 16'h91F1, 16'hA177, 16'h91F2, 16'hF000,
      16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000}
  };
  int    exp_cnt [N_TESTS] = '{3, 2, 3, 3, 3, 1};
  word_t exp_addr [N_TESTS][4] = '{
    '{16'h0080, 16'h0082, 16'h0084, 16'h0000},
    '{16'h0080, 16'h007E, 16'h0000, 16'h0000},  // Negative offset
    '{16'h0080, 16'h0082, 16'h0084, 16'h0000},
    '{16'h0080, 16'h0082, 16'h0084, 16'h0000},
    '{16'h0080, 16'h0082, 16'h0084, 16'h0000},
    '{16'h0080, 16'h0000, 16'h0000, 16'h0000}   // Nothing after HLT
  };
  word_t exp_data [N_TESTS][4] = '{
    '{16'h68AC, 16'h4444, 16'h444C, 16'h0000},  // Sum, difference, xor
    '{16'h000A, 16'h000F, 16'h0000, 16'h0000},
    '{16'h4321, 16'h8642, 16'h8642, 16'h0000},
    '{16'h0000, 16'h0022, 16'h0033, 16'h0000},  // Shadow LLBs skipped
    '{16'h8000, 16'h0000, 16'h0066, 16'h0000},
    '{16'h005A, 16'h0000, 16'h0000, 16'h0000}
  };

  always #20 clk = ~clk;  // 40 ns period

  proc #(.RESET_PC(16'h0000)) proc_inst (
    .clk(clk), .arst_n(arst_n),
    .mem_data_valid(mem_data_valid), .mem_data_in(mem_data_in),
    .mem_en(mem_en), .mem_addr(mem_addr), .mem_wr(mem_wr),
    .mem_data_out(mem_data_out), .hlt(hlt), .pc(pc)
  );

  proc_mem_model #(.SEED(25580)) mem_model_inst (
    .clk(clk), .arst_n(arst_n),
    .mem_en(mem_en), .mem_addr(mem_addr), .mem_wr(mem_wr),
    .mem_data_out(mem_data_out),
    .mem_data_valid(mem_data_valid), .mem_data_in(mem_data_in)
  );

  // Reset 3 cycles, program at word 0, NOP fill marked with the address
  task automatic reset_and_load(input int t);
    @(posedge clk);
    #2 arst_n = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem_model_inst.mem[i] = (i < 16) ? program_tab[t][i] : {8'hE0, i[7:0]};
    end
    repeat (3) @(posedge clk);
    #2 arst_n = 1'b1;
  endtask

  task automatic wait_for_halt(output bit ok);
    ok = 1'b0;
    for (int c = 0; c < HLT_TIMEOUT; c++) begin
      @(negedge clk);
      if (hlt) begin
        ok = 1'b1;
        break;
      end
    end
  endtask

  task automatic check_stores(input int t);
    int n;
    n = mem_model_inst.log_cnt;
    if (n != exp_cnt[t]) begin
      $display("Error %s: store count expected %0d, actual %0d", test_name[t], exp_cnt[t], n);
      errors++;
    end
    for (int i = 0; i < exp_cnt[t] && i < n; i++) begin
      if (mem_model_inst.log_addr[i] !== exp_addr[t][i] ||
          mem_model_inst.log_data[i] !== exp_data[t][i]) begin
        $display("Error %s: store %0d expected [%h]=%h, actual [%h]=%h", test_name[t], i,
                 exp_addr[t][i], exp_data[t][i],
                 mem_model_inst.log_addr[i], mem_model_inst.log_data[i]);
        errors++;
      end
    end
  endtask

  // hlt held, no requests and pc frozen for a while
  task automatic check_halt_hold(input int t);
    word_t pc_at_hlt;
    int    req_at_hlt;
    pc_at_hlt  = pc;
    req_at_hlt = mem_model_inst.req_cnt;
    for (int c = 0; c < HOLD_CYCLES; c++) begin
      @(negedge clk);
      if (!hlt || mem_en || pc !== pc_at_hlt) begin
        $display("Error %s: core left halt state, hlt=%b mem_en=%b pc expected %h, actual %h",
                 test_name[t], hlt, mem_en, pc_at_hlt, pc);
        errors++;
        break;
      end
    end
    if (mem_model_inst.req_cnt != req_at_hlt) begin
      $display("Error %s: memory requests expected %0d, actual %0d", test_name[t],
               req_at_hlt, mem_model_inst.req_cnt);
      errors++;
    end
  endtask

  initial begin
    int err_before;
    bit got_hlt;
    int n_failed;
    clk      = 1'b0;
    arst_n   = 1'b0;
    errors   = 0;
    n_failed = 0;
    for (int t = 0; t < N_TESTS; t++) begin
      err_before = errors;
      reset_and_load(t);
      wait_for_halt(got_hlt);
      if (!got_hlt) begin
        $display("Error %s: hlt never rose within %0d cycles", test_name[t], HLT_TIMEOUT);
        errors++;
      end else begin
        check_stores(t);
        check_halt_hold(t);
      end
      if (errors == err_before) begin
        $display("Test %0d %s: passed", t + 1, test_name[t]);
      end else begin
        $display("Test %0d %s: failed", t + 1, test_name[t]);
        n_failed++;
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d", N_TESTS,
             N_TESTS - n_failed, n_failed, errors);
    if (n_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
design/cpu_pkg.sv
design/pipe_reg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/hazard_unit.sv
design/execute_unit.sv
design/mem_arbiter.sv
design/proc.sv
verification/proc_mem_model.sv
verification/proc_tb.sv

// File: Makefile
# Verilator flow for the pipelined core
VERILATOR ?= verilator
TOP       ?= proc_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
